//--- design/ucodePkg.sv
package ucodePkg;

	////////////////////////////////////////////////////////////
	// Field widths
	////////////////////////////////////////////////////////////

	typedef logic [7:0] opcodeT;
	typedef logic [6:0] uAddrT;
	typedef logic [3:0] flowCtrlT;
	typedef logic [4:0] uopCmdT;
	typedef logic [4:0] uopOperandT;

	// Sequencer states
	typedef enum logic [1:0] {Idle, Dispatch, Run} seqStateT;

	////////////////////////////////////////////////////////////
	// Flow-control field
	////////////////////////////////////////////////////////////

	localparam flowCtrlT flowOp          = 4'd0;
	localparam flowCtrlT flowInc         = 4'd1;
	localparam flowCtrlT flowEof         = 4'd2;
	localparam flowCtrlT flowIncEof      = 4'd3;
	localparam flowCtrlT flowIncEofFu    = 4'd4;
	localparam flowCtrlT flowEofFu       = 4'd5;
	localparam flowCtrlT flowUpdateFlags = 4'd6;
	// Conditional ends, tested against the zero flag
	localparam flowCtrlT flowIncEofZ     = 4'd7;
	localparam flowCtrlT flowIncEofNz    = 4'd8;

	// Micro-commands for the datapath
	localparam uopCmdT cmdNop     = 5'd0;
	localparam uopCmdT cmdSma     = 5'd1;
	localparam uopCmdT cmdSrm     = 5'd2;
	localparam uopCmdT cmdInc16   = 5'd3;
	localparam uopCmdT cmdDec16   = 5'd4;
	localparam uopCmdT cmdSx16r   = 5'd5;
	localparam uopCmdT cmdSrx16   = 5'd6;
	localparam uopCmdT cmdAddx16  = 5'd7;
	localparam uopCmdT cmdAddx16u = 5'd8;
	localparam uopCmdT cmdSubx16  = 5'd9;
	localparam uopCmdT cmdSpc     = 5'd10;
	localparam uopCmdT cmdJcb     = 5'd11;
	localparam uopCmdT cmdBit     = 5'd12;
	localparam uopCmdT cmdShr     = 5'd13;
	localparam uopCmdT cmdRrot    = 5'd14;
	localparam uopCmdT cmdZ801bop = 5'd15;

	// Operand selects
	localparam uopOperandT opNull = 5'd0;
	localparam uopOperandT opA    = 5'd1;
	localparam uopOperandT opB    = 5'd2;
	localparam uopOperandT opC    = 5'd3;
	localparam uopOperandT opPc   = 5'd4;
	localparam uopOperandT opX8   = 5'd5;
	localparam uopOperandT opX16  = 5'd6;

	////////////////////////////////////////////////////////////
	// Flow start addresses in the ROM
	////////////////////////////////////////////////////////////

	localparam uAddrT flowDefault   = 7'd0;
	localparam uAddrT flowNop       = 7'd2;
	localparam uAddrT flowLdA       = 7'd3;
	localparam uAddrT flowLdB       = 7'd6;
	localparam uAddrT flowLdC       = 7'd9;
	localparam uAddrT flowIncB      = 7'd12;
	localparam uAddrT flowIncC      = 7'd13;
	localparam uAddrT flowDecA      = 7'd14;
	localparam uAddrT flowDecC      = 7'd15;
	localparam uAddrT flowAddB      = 7'd16;
	localparam uAddrT flowSubB      = 7'd19;
	localparam uAddrT flowJr        = 7'd22;
	localparam uAddrT flowJrNz      = 7'd28;
	localparam uAddrT flowJrZ       = 7'd34;
	localparam uAddrT flowMapCb     = 7'd40;
	localparam uAddrT flowCbBit7    = 7'd43;
	localparam uAddrT flowCbSrlB    = 7'd44;
	localparam uAddrT flowCbRr      = 7'd46;
	localparam uAddrT flowCbInvalid = 7'd48;

endpackage

//--- design/opcodeDispatch.sv
`timescale 1ns/1ns

module opcodeDispatch
	import ucodePkg::*;
(
	input  opcodeT opcode,
	input  logic   cbMode,
	output uAddrT  flowStart
);

	uAddrT mainStart;
	uAddrT cbStart;

	////////////////////////////////////////////////////////////
	// Main opcode table
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (opcode)
			8'h00:
				mainStart = flowNop;
			8'h3E:
				mainStart = flowLdA;
			8'h06:
				mainStart = flowLdB;
			8'h0E:
				mainStart = flowLdC;
			8'h04:
				mainStart = flowIncB;
			8'h0C:
				mainStart = flowIncC;
			8'h3D:
				mainStart = flowDecA;
			8'h0D:
				mainStart = flowDecC;
			8'h80:
				mainStart = flowAddB;
			8'h90:
				mainStart = flowSubB;
			8'h18:
				mainStart = flowJr;
			8'h20:
				mainStart = flowJrNz;
			8'h28:
				mainStart = flowJrZ;
			// Prefix byte, fetches the extended opcode
			8'hCB:
				mainStart = flowMapCb;
			default:
				mainStart = flowDefault;
		endcase
	end

	////////////////////////////////////////////////////////////
	// CB extended table
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (opcode)
			8'h7C:
				cbStart = flowCbBit7;
			8'h38:
				cbStart = flowCbSrlB;
			// RR B, C, D, E, H, L, (HL), A share one flow
			8'h18, 8'h19, 8'h1A, 8'h1B, 8'h1C, 8'h1D, 8'h1E, 8'h1F:
				cbStart = flowCbRr;
			default:
				cbStart = flowCbInvalid;
		endcase
	end

	// Prefix seen on the previous dispatch selects the CB table
	assign flowStart = cbMode ? cbStart : mainStart;

endmodule

//--- design/ucodeRom.sv
`timescale 1ns/1ns

module ucodeRom
	import ucodePkg::*;
(
	input  uAddrT      uAddr,
	output flowCtrlT   uopFlow,
	output uopCmdT     uopCmd,
	output uopOperandT uopOperand
);

	// Flow, command and operand packed side by side
	logic [$bits(flowCtrlT) + $bits(uopCmdT) + $bits(uopOperandT) - 1:0] uopWord;

	always_comb
	begin
		case (uAddr)
			////////////////////////////////////////////////////////////
			// One-byte fallback and NOP
			////////////////////////////////////////////////////////////
			7'd0:  uopWord = {flowUpdateFlags, cmdZ801bop, opA};
			7'd1:  uopWord = {flowIncEof, cmdNop, opNull};
			7'd2:  uopWord = {flowIncEof, cmdNop, opNull};

			////////////////////////////////////////////////////////////
			// LD r,n
			////////////////////////////////////////////////////////////
			// LD A,n
			7'd3:  uopWord = {flowInc, cmdSma, opPc};
			7'd4:  uopWord = {flowInc, cmdNop, opNull};
			7'd5:  uopWord = {flowEof, cmdSrm, opA};
			// LD B,n
			7'd6:  uopWord = {flowInc, cmdSma, opPc};
			7'd7:  uopWord = {flowInc, cmdNop, opNull};
			7'd8:  uopWord = {flowEof, cmdSrm, opB};
			// LD C,n
			7'd9:  uopWord = {flowInc, cmdSma, opPc};
			7'd10: uopWord = {flowInc, cmdNop, opNull};
			7'd11: uopWord = {flowEof, cmdSrm, opC};

			////////////////////////////////////////////////////////////
			// INC and DEC
			////////////////////////////////////////////////////////////
			7'd12: uopWord = {flowIncEofFu, cmdInc16, opB};
			7'd13: uopWord = {flowIncEofFu, cmdInc16, opC};
			7'd14: uopWord = {flowIncEofFu, cmdDec16, opA};
			7'd15: uopWord = {flowIncEofFu, cmdDec16, opC};

			////////////////////////////////////////////////////////////
			// ALU through the 16-bit scratch register
			////////////////////////////////////////////////////////////
			// ADD A,B
			7'd16: uopWord = {flowOp, cmdSx16r, opA};
			7'd17: uopWord = {flowUpdateFlags, cmdAddx16u, opB};
			7'd18: uopWord = {flowIncEof, cmdSrx16, opA};
			// SUB A,B
			7'd19: uopWord = {flowOp, cmdSx16r, opA};
			7'd20: uopWord = {flowUpdateFlags, cmdSubx16, opB};
			7'd21: uopWord = {flowIncEof, cmdSrx16, opA};

			////////////////////////////////////////////////////////////
			// Relative jumps
			////////////////////////////////////////////////////////////
			// JR n
			7'd22: uopWord = {flowInc, cmdSma, opPc};
			7'd23: uopWord = {flowOp, cmdNop, opNull};
			7'd24: uopWord = {flowInc, cmdSrm, opX8};
			7'd25: uopWord = {flowOp, cmdSx16r, opPc};
			7'd26: uopWord = {flowOp, cmdAddx16, opX8};
			7'd27: uopWord = {flowEof, cmdSpc, opX16};
			// JR NZ,n, falls out early when zero is set
			7'd28: uopWord = {flowInc, cmdSma, opPc};
			7'd29: uopWord = {flowOp, cmdNop, opNull};
			7'd30: uopWord = {flowIncEofZ, cmdSrm, opX8};
			7'd31: uopWord = {flowOp, cmdSx16r, opPc};
			7'd32: uopWord = {flowOp, cmdAddx16, opX8};
			7'd33: uopWord = {flowEof, cmdSpc, opX16};
			// JR Z,n
			7'd34: uopWord = {flowInc, cmdSma, opPc};
			7'd35: uopWord = {flowOp, cmdNop, opNull};
			7'd36: uopWord = {flowIncEofNz, cmdSrm, opX8};
			7'd37: uopWord = {flowOp, cmdSx16r, opPc};
			7'd38: uopWord = {flowOp, cmdAddx16, opX8};
			7'd39: uopWord = {flowEof, cmdSpc, opX16};

			////////////////////////////////////////////////////////////
			// CB prefix map
			////////////////////////////////////////////////////////////
			7'd40: uopWord = {flowInc, cmdSma, opPc};
			7'd41: uopWord = {flowOp, cmdNop, opNull};
			// Jump back to dispatch with the CB table selected
			7'd42: uopWord = {flowInc, cmdJcb, opNull};

			////////////////////////////////////////////////////////////
			// CB extended flows
			////////////////////////////////////////////////////////////
			// BIT 7
			7'd43: uopWord = {flowEofFu, cmdBit, opNull};
			// SRL B
			7'd44: uopWord = {flowUpdateFlags, cmdShr, opNull};
			7'd45: uopWord = {flowEof, cmdNop, opNull};
			// RR group
			7'd46: uopWord = {flowUpdateFlags, cmdRrot, opNull};
			7'd47: uopWord = {flowEof, cmdNop, opNull};
			// Unknown CB opcode
			7'd48: uopWord = {flowEof, cmdNop, opNull};

			default:
				uopWord = {flowOp, cmdNop, opNull};
		endcase
	end

	assign {uopFlow, uopCmd, uopOperand} = uopWord;

endmodule

//--- design/ucodeSequencer.sv
`timescale 1ns/1ns

module ucodeSequencer
	import ucodePkg::*;
(
	input  logic     clock,
	input  logic     rstN,
	input  uAddrT    flowStart,
	input  flowCtrlT uopFlow,
	input  uopCmdT   uopCmd,
	input  logic     zeroFlag,
	output uAddrT    uAddr,
	output logic     cbMode,
	output logic     uopValid,
	output logic     instrDone
);

	seqStateT state;
	seqStateT stateNext;
	uAddrT    uPc;
	logic     inRun;
	logic     endOfFlow;
	logic     cbJump;

	////////////////////////////////////////////////////////////
	// End-of-flow decode
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (uopFlow)
			flowEof, flowIncEof, flowIncEofFu, flowEofFu:
				endOfFlow = 1'b1;
			// Conditional ends look at the flag in this same cycle
			flowIncEofZ:
				endOfFlow = zeroFlag;
			flowIncEofNz:
				endOfFlow = !zeroFlag;
			default:
				endOfFlow = 1'b0;
		endcase
	end

	assign cbJump = (uopCmd == cmdJcb);
	assign inRun  = (state == Run);

	// Micro-op is live only while running a flow
	assign uopValid  = inRun;
	assign instrDone = inRun && endOfFlow && !cbJump;
	assign uAddr     = uPc;

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////

	always_comb
	begin
		stateNext = state;
		case (state)
			Idle:
				stateNext = Dispatch;
			Dispatch:
				stateNext = Run;
			Run:
			begin
				if (cbJump || endOfFlow)
				begin
					stateNext = Dispatch;
				end
			end
			default:
				stateNext = Idle;
		endcase
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			state  <= Idle;
			uPc    <= '0;
			cbMode <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			if (state == Dispatch)
			begin
				uPc    <= flowStart;
				cbMode <= 1'b0;
			end
			else if (inRun)
			begin
				if (cbJump)
					cbMode <= 1'b1;
				else
					uPc <= uPc + uAddrT'(1);
			end
		end
	end

endmodule

//--- design/ucodeEngine.sv
`timescale 1ns/1ns

module ucodeEngine
	import ucodePkg::*;
(
	input  logic       clock,
	input  logic       rstN,
	input  opcodeT     opcode,
	input  logic       zeroFlag,
	// Kept for carry-conditioned flows, none of which are in the ROM
	input  logic       carryFlag,
	output flowCtrlT   uopFlow,
	output uopCmdT     uopCmd,
	output uopOperandT uopOperand,
	output logic       uopValid,
	output logic       instrDone
);

	uAddrT flowStart;
	uAddrT uAddr;
	logic  cbMode;

	// Opcode to flow start, main or CB table
	opcodeDispatch i_dispatch (
		.opcode    (opcode),
		.cbMode    (cbMode),
		.flowStart (flowStart)
	);

	ucodeRom i_rom (
		.uAddr      (uAddr),
		.uopFlow    (uopFlow),
		.uopCmd     (uopCmd),
		.uopOperand (uopOperand)
	);

	ucodeSequencer i_sequencer (
		.clock     (clock),
		.rstN      (rstN),
		.flowStart (flowStart),
		.uopFlow   (uopFlow),
		.uopCmd    (uopCmd),
		.zeroFlag  (zeroFlag),
		.uAddr     (uAddr),
		.cbMode    (cbMode),
		.uopValid  (uopValid),
		.instrDone (instrDone)
	);

endmodule

//--- test/ucodeEngine_checker.sv
`timescale 1ns/1ns

module ucodeEngineChecker
(
	input logic clock,
	input logic rstN,
	input logic uopValid,
	input logic instrDone
);

	////////////////////////////////////////////////////////////
	// Control output rules
	////////////////////////////////////////////////////////////

	// End of instruction only on a live micro-op
	doneNeedsValid: assert property (
		@(posedge clock) disable iff (!rstN)
		instrDone |-> uopValid
	) else $error("instrDone high without uopValid");

	// Dispatch follows every end of flow
	dispatchAfterDone: assert property (
		@(posedge clock) disable iff (!rstN)
		instrDone |=> !uopValid
	) else $error("uopValid high in the cycle after instrDone");

	// Quiet in reset
	quietInReset: assert property (
		@(posedge clock)
		!rstN |-> (!uopValid && !instrDone)
	) else $error("control outputs high while in reset");

endmodule

//--- test/ucodeEngineTb.sv
`timescale 1ns/1ns

module ucodeEngineTb
	import ucodePkg::*;
();

	localparam int clockPeriod   = 40;
	localparam int driveDelay    = 2;
	localparam int cyclesPerTest = 20;
	localparam string testsPath  = "test/ucodeEngineTests.txt";

	logic       clock = 1'b0;
	logic       rstN;
	opcodeT     opcode;
	logic       zeroFlag;
	logic       carryFlag;
	flowCtrlT   uopFlow;
	uopCmdT     uopCmd;
	uopOperandT uopOperand;
	logic       uopValid;
	logic       instrDone;

	// One entry per line of the tests file
	opcodeT     opList[$];
	logic       cbList[$];
	opcodeT     cbOpList[$];
	logic       zeroList[$];
	int         countList[$];
	uopCmdT     firstCmdList[$];
	uopOperandT firstOperList[$];
	uopCmdT     lastCmdList[$];
	uopOperandT lastOperList[$];

	int   numTests = 0;
	int   watchdogNs = 0;
	logic loaded = 1'b0;

	always #(clockPeriod / 2) clock = ~clock;

	ucodeEngine i_dut (
		.clock      (clock),
		.rstN       (rstN),
		.opcode     (opcode),
		.zeroFlag   (zeroFlag),
		.carryFlag  (carryFlag),
		.uopFlow    (uopFlow),
		.uopCmd     (uopCmd),
		.uopOperand (uopOperand),
		.uopValid   (uopValid),
		.instrDone  (instrDone)
	);

	bind ucodeEngine ucodeEngineChecker i_checker (
		.clock     (clock),
		.rstN      (rstN),
		.uopValid  (uopValid),
		.instrDone (instrDone)
	);

	task automatic checkValue(input int actual, input int expected, input string what);
		begin
			if (actual !== expected)
			begin
				$display("FAIL %0t ns: %s, got %0h, expected %0h",
					$time, what, actual, expected);
				$display("TESTS FAILED");
				$fatal(1, "value mismatch");
			end
		end
	endtask

	// Whether a flow-control code ends the flow for the given zero flag
	function automatic logic endsFlow(input flowCtrlT flow, input logic zero);
		logic ends;
		begin
			ends = 1'b0;
			if (flow == flowEof || flow == flowIncEof)
				ends = 1'b1;
			else if (flow == flowIncEofFu || flow == flowEofFu)
				ends = 1'b1;
			else if (flow == flowIncEofZ)
				ends = zero;
			else if (flow == flowIncEofNz)
				ends = !zero;
			return ends;
		end
	endfunction

	////////////////////////////////////////////////////////////
	// Tests file
	////////////////////////////////////////////////////////////

	task automatic loadTests();
		int         fd;
		int         fields;
		string      line;
		opcodeT     op;
		logic       cb;
		opcodeT     cbOp;
		logic       zero;
		int         count;
		uopCmdT     fCmd;
		uopOperandT fOper;
		uopCmdT     lCmd;
		uopOperandT lOper;
		begin
			fd = $fopen(testsPath, "r");
			if (fd == 0)
			begin
				$display("Could not open the tests file %s", testsPath);
				$display("TESTS FAILED");
				$fatal(1, "missing tests file");
			end
			while ($fgets(line, fd) != 0)
			begin
				// Skip column notes and empty lines
				if (line.len() > 1 && line[0] != "#")
				begin
					fields = $sscanf(line, "%h %h %h %h %d %h %h %h %h",
						op, cb, cbOp, zero, count, fCmd, fOper, lCmd, lOper);
					if (fields != 9)
					begin
						$display("A line of the tests file is malformed: %s", line);
						$display("TESTS FAILED");
						$fatal(1, "bad tests file");
					end
					opList.push_back(op);
					cbList.push_back(cb);
					cbOpList.push_back(cbOp);
					zeroList.push_back(zero);
					countList.push_back(count);
					firstCmdList.push_back(fCmd);
					firstOperList.push_back(fOper);
					lastCmdList.push_back(lCmd);
					lastOperList.push_back(lOper);
				end
			end
			$fclose(fd);
			numTests = opList.size();
		end
	endtask

	////////////////////////////////////////////////////////////
	// One instruction from its Dispatch cycle on
	////////////////////////////////////////////////////////////

	task automatic runTest(input int idx);
		int         flowCount;
		int         mapCount;
		logic       cbPending;
		logic       cbDispatched;
		logic       finished;
		logic       atEnd;
		uopCmdT     firstCmd;
		uopOperandT firstOper;
		uopCmdT     lastCmd;
		uopOperandT lastOper;
		begin
			flowCount    = 0;
			mapCount     = 0;
			cbPending    = 1'b0;
			cbDispatched = 1'b0;
			finished     = 1'b0;
			atEnd        = 1'b0;
			firstCmd     = cmdNop;
			firstOper    = opNull;
			lastCmd      = cmdNop;
			lastOper     = opNull;
			opcode   = opList[idx];
			zeroFlag = zeroList[idx];
			@(negedge clock);
			checkValue(int'(uopValid), 0, $sformatf("test %0d uopValid in dispatch", idx));
			checkValue(int'(instrDone), 0, $sformatf("test %0d instrDone in dispatch", idx));
			while (!finished)
			begin
				@(posedge clock);
				#(driveDelay);
				// Extended opcode goes in during the second dispatch
				if (cbPending)
					opcode = cbOpList[idx];
				@(negedge clock);
				if (cbPending)
				begin
					checkValue(int'(uopValid), 0,
						$sformatf("test %0d uopValid in CB dispatch", idx));
					cbPending    = 1'b0;
					cbDispatched = 1'b1;
				end
				else
				begin
					checkValue(int'(uopValid), 1, $sformatf("test %0d uopValid in flow", idx));
					if (uopCmd == cmdJcb)
					begin
						checkValue(int'(cbList[idx]), 1, $sformatf("test %0d CB jump", idx));
						checkValue(int'(instrDone), 0,
							$sformatf("test %0d instrDone on CB jump", idx));
						mapCount  = flowCount + 1;
						flowCount = 0;
						cbPending = 1'b1;
					end
					else
					begin
						if (flowCount == 0)
						begin
							firstCmd  = uopCmd;
							firstOper = uopOperand;
						end
						flowCount++;
						lastCmd  = uopCmd;
						lastOper = uopOperand;
						// Only the listed last micro-op of the final flow may end it
						atEnd = (!cbList[idx] || cbDispatched) &&
							(flowCount == countList[idx]);
						checkValue(int'(endsFlow(uopFlow, zeroFlag)), int'(atEnd),
							$sformatf("test %0d flow field of micro-op %0d", idx, flowCount));
						if (instrDone)
							finished = 1'b1;
					end
				end
			end
			checkValue(int'(cbDispatched), int'(cbList[idx]),
				$sformatf("test %0d CB dispatch", idx));
			if (cbList[idx])
				checkValue(mapCount, 3, $sformatf("test %0d CB map length", idx));
			checkValue(flowCount, countList[idx], $sformatf("test %0d micro-op count", idx));
			checkValue(int'(firstCmd), int'(firstCmdList[idx]),
				$sformatf("test %0d first cmd", idx));
			checkValue(int'(firstOper), int'(firstOperList[idx]),
				$sformatf("test %0d first operand", idx));
			checkValue(int'(lastCmd), int'(lastCmdList[idx]),
				$sformatf("test %0d last cmd", idx));
			checkValue(int'(lastOper), int'(lastOperList[idx]),
				$sformatf("test %0d last operand", idx));
			// Next cycle is the following Dispatch
			@(posedge clock);
			#(driveDelay);
		end
	endtask

	initial
	begin
		rstN      = 1'b0;
		opcode    = '0;
		zeroFlag  = 1'b0;
		carryFlag = 1'b0;
		loadTests();
		watchdogNs = (numTests * cyclesPerTest + 10) * clockPeriod;
		loaded     = 1'b1;
		// Two reset cycles
		@(negedge clock);
		checkValue(int'(uopValid), 0, "uopValid in reset");
		checkValue(int'(instrDone), 0, "instrDone in reset");
		@(posedge clock);
		#(driveDelay);
		rstN = 1'b1;
		// Idle cycle
		@(negedge clock);
		checkValue(int'(uopValid), 0, "uopValid after reset");
		checkValue(int'(instrDone), 0, "instrDone after reset");
		@(posedge clock);
		#(driveDelay);
		for (int i = 0; i < numTests; i++)
		begin
			runTest(i);
		end
		if (numTests > 0)
		begin
			$display("TESTS PASSED");
			$finish;
		end
		else
		begin
			$display("The tests file holds no tests");
			$display("TESTS FAILED");
			$fatal(1, "no tests run");
		end
	end

	// Watchdog
	initial
	begin
		wait (loaded);
		#(watchdogNs);
		$display("Timeout: the tests were still running after %0d ns", watchdogNs);
		$display("TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- test/ucodeEngineTests.txt
# opcode cbFlag cbOpcode zeroFlag uopCount firstCmd firstOperand lastCmd lastOperand
# all hex except uopCount; the micro-op fields describe the final flow after any CB map
00 0 00 0 1 00 00 00 00
3E 0 00 0 3 01 04 02 01
06 0 00 0 3 01 04 02 02
0E 0 00 0 3 01 04 02 03
04 0 00 0 1 03 02 03 02
0C 0 00 0 1 03 03 03 03
3D 0 00 0 1 04 01 04 01
0D 0 00 0 1 04 03 04 03
80 0 00 0 3 05 01 06 01
90 0 00 0 3 05 01 06 01
18 0 00 0 6 01 04 0A 06
20 0 00 1 3 01 04 02 05
20 0 00 0 6 01 04 0A 06
28 0 00 0 3 01 04 02 05
28 0 00 1 6 01 04 0A 06
CB 1 7C 0 1 0C 00 0C 00
CB 1 38 0 2 0D 00 00 00
CB 1 18 0 2 0E 00 00 00
CB 1 1F 0 2 0E 00 00 00
CB 1 55 0 1 00 00 00 00
76 0 00 0 2 0F 01 00 00
FF 0 00 1 2 0F 01 00 00

//--- ucodeEngine.f
design/ucodePkg.sv
design/opcodeDispatch.sv
design/ucodeRom.sv
design/ucodeSequencer.sv
design/ucodeEngine.sv
test/ucodeEngine_checker.sv
test/ucodeEngineTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the microcode engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f ucodeEngine.f \
	--top-module ucodeEngineTb -o ucodeEngineSim

simOutput=$(./obj_dir/ucodeEngineSim 2>&1) || true
echo "$simOutput"

if grep -q "TESTS PASSED" <<< "$simOutput"; then
	exit 0
else
	exit 1
fi
